/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dcache_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST FAILED
PASS_MSG  = TEST PASSED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
rtl/dcache_pkg.sv
rtl/dcache_array_if.sv
rtl/dcache_arrays.sv
rtl/dcache_plru.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/tb_clock.sv
test/dcache_chk.sv
test/dcache_tb.sv

/* rtl/dcache_array_if.sv */
`timescale 1ns/100ps

interface dcache_array_if
    import dcache_pkg::*;
#(
    parameter int SET_W = DEFAULT_SET_W
);

    localparam int OFF_W  = $clog2(WORDS_PER_LINE * WORD_W / 8);
    localparam int WIDX_W = $clog2(WORDS_PER_LINE);
    localparam int TAG_W  = ADDR_W - SET_W - OFF_W;

    logic                               rd_en;
    logic [SET_W-1:0]                   rd_set;
    logic [WIDX_W-1:0]                  rd_word;

    logic [BUS_W/WORD_W-1:0]            wr_en;      // word enables within the beat
    way_t                               wr_way;
    logic [SET_W+WIDX_W-1:0]            wr_word;    // set and word
    beat_t                              wr_data;

    logic                               tag_en;
    way_t                               tag_way;
    logic [SET_W-1:0]                   tag_set;
    logic [TAG_W-1:0]                   tag;
    logic                               tag_valid;
    logic                               tag_dirty;

    logic [NUM_WAYS-1:0][TAG_W-1:0]     rd_tags;
    way_vec_t                           rd_valid;
    way_vec_t                           rd_dirty;
    beat_t [NUM_WAYS-1:0]               rd_data;    // whole beat per way

    modport ctrl (
        output rd_en, rd_set, rd_word,
        output wr_en, wr_way, wr_word, wr_data,
        output tag_en, tag_way, tag_set, tag, tag_valid, tag_dirty,
        input  rd_tags, rd_valid, rd_dirty, rd_data
    );

    modport mem (
        input  rd_en, rd_set, rd_word,
        input  wr_en, wr_way, wr_word, wr_data,
        input  tag_en, tag_way, tag_set, tag, tag_valid, tag_dirty,
        output rd_tags, rd_valid, rd_dirty, rd_data
    );

endinterface

/* rtl/dcache_arrays.sv */
`timescale 1ns/100ps

module dcache_arrays
    import dcache_pkg::*;
#(
    parameter int SET_W = DEFAULT_SET_W
)(
    input logic         clk,
    input logic         resetn,
    dcache_array_if.mem arr
);

    localparam int NUM_SETS = 1 << SET_W;
    localparam int OFF_W    = $clog2(WORDS_PER_LINE * WORD_W / 8);
    localparam int WIDX_W   = $clog2(WORDS_PER_LINE);
    localparam int TAG_W    = ADDR_W - SET_W - OFF_W;
    localparam int WPB      = BUS_W / WORD_W;
    localparam int ROW_W    = SET_W + WIDX_W - 1;
    localparam int ROWS     = NUM_SETS * BEATS_PER_LINE;

    logic [TAG_W-1:0]               tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;
    beat_t                          data_mem [NUM_WAYS][ROWS];

    logic [ROW_W-1:0]               rd_row;
    logic [ROW_W-1:0]               wr_row;
    logic [NUM_WAYS-1:0][TAG_W-1:0] tag_fwd;
    way_vec_t                       valid_fwd;
    way_vec_t                       dirty_fwd;
    beat_t [NUM_WAYS-1:0]           data_fwd;

    assign rd_row = {arr.rd_set, arr.rd_word[WIDX_W-1:1]};  // one row per beat
    assign wr_row = arr.wr_word[SET_W+WIDX_W-1:1];

    always_ff @(posedge clk) begin
        if (arr.tag_en) begin
            tag_mem[arr.tag_way][arr.tag_set] <= arr.tag;
        end
        for (int h = 0; h < WPB; h++) begin
            if (arr.wr_en[h]) begin
                data_mem[arr.wr_way][wr_row][h*WORD_W +: WORD_W] <= arr.wr_data[h*WORD_W +: WORD_W];
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.tag_en) begin
            valid_q[arr.tag_way][arr.tag_set] <= arr.tag_valid;
            dirty_q[arr.tag_way][arr.tag_set] <= arr.tag_dirty;
        end
    end

    // same-cycle writes win over the stored contents
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_fwd[w]   = tag_mem[w][arr.rd_set];
            valid_fwd[w] = valid_q[w][arr.rd_set];
            dirty_fwd[w] = dirty_q[w][arr.rd_set];
            data_fwd[w]  = data_mem[w][rd_row];
            if (arr.tag_en && arr.tag_way == way_t'(w) && arr.tag_set == arr.rd_set) begin
                tag_fwd[w]   = arr.tag;
                valid_fwd[w] = arr.tag_valid;
                dirty_fwd[w] = arr.tag_dirty;
            end
            for (int h = 0; h < WPB; h++) begin
                if (arr.wr_en[h] && arr.wr_way == way_t'(w) && wr_row == rd_row) begin
                    data_fwd[w][h*WORD_W +: WORD_W] = arr.wr_data[h*WORD_W +: WORD_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            arr.rd_tags <= tag_fwd;
            arr.rd_data <= data_fwd;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            arr.rd_valid <= '0;
            arr.rd_dirty <= '0;
        end else if (arr.rd_en) begin
            arr.rd_valid <= valid_fwd;
            arr.rd_dirty <= dirty_fwd;
        end
    end

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int SET_W = DEFAULT_SET_W
)(
    input  logic            clk,
    input  logic            resetn,

    input  logic            req_i,
    input  addr_t           addr_i,
    input  logic            wr_i,
    input  word_t           wr_data_i,
    input  mask_t           mask_i,
    output logic            ready_o,
    output logic            resp_valid_o,
    output word_t           rd_data_o,

    input  logic            arready_i,
    output addr_t           araddr_o,
    output logic            arvalid_o,
    input  logic            rvalid_i,
    input  beat_t           rdata_i,
    output logic            rready_o,
    input  logic            awready_i,
    output addr_t           awaddr_o,
    output logic            awvalid_o,
    input  logic            wready_i,
    output beat_t           wdata_o,
    output logic            wvalid_o,
    output logic            wlast_o,
    input  logic            bvalid_i,
    output logic            bready_o,

    dcache_array_if.ctrl    arr,

    output logic            touch_en_o,
    output way_t            touch_way_o,
    output way_vec_t        valid_vec_o,
    input  way_t            victim_i
);

    localparam int OFF_W  = $clog2(WORDS_PER_LINE * WORD_W / 8);
    localparam int BYTE_W = $clog2(WORD_W / 8);
    localparam int WIDX_W = $clog2(WORDS_PER_LINE);
    localparam int TAG_W  = ADDR_W - SET_W - OFF_W;
    localparam int WPB    = BUS_W / WORD_W;

    ctrl_state_t        state;
    logic               req_q;      // request in lookup
    addr_t              addr_q;
    logic               wr_q;
    word_t              wdata_q;
    mask_t              mask_q;
    way_t               way_q;      // victim way of the miss
    logic [TAG_W-1:0]   vtag_q;
    word_t              crit_q;
    beat_cnt_t          beat_cnt;

    logic [TAG_W-1:0]   req_tag;
    logic [SET_W-1:0]   req_set;
    logic [WIDX_W-1:0]  req_word;
    way_vec_t           hit_vec;
    way_t               hit_way;
    logic               hit;
    logic               miss;
    logic               accept;
    logic               victim_dirty;
    word_t              hit_word;
    word_t              merged;
    beat_cnt_t          beat_nxt;

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, mask_t m);
        word_t res;
        res = old_w;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (m[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign req_tag  = addr_q[ADDR_W-1 -: TAG_W];
    assign req_set  = addr_q[OFF_W +: SET_W];
    assign req_word = addr_q[BYTE_W +: WIDX_W];

    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = arr.rd_valid[w] && (arr.rd_tags[w] == req_tag);
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit          = (state == RUN) && req_q && (|hit_vec);
    assign miss         = (state == RUN) && req_q && !(|hit_vec);
    assign ready_o      = (state == RUN) && !miss;
    assign accept       = req_i && ready_o;
    assign victim_dirty = arr.rd_valid[victim_i] && arr.rd_dirty[victim_i];
    assign hit_word     = arr.rd_data[hit_way][req_word[0]*WORD_W +: WORD_W];
    assign merged       = merge_bytes((state == FILL_DONE) ? crit_q : hit_word, wdata_q, mask_q);
    assign beat_nxt     = beat_cnt + {1'b0, (wvalid_o && wready_i)};   // wb reads one beat ahead

    assign valid_vec_o  = arr.rd_valid;
    assign touch_en_o   = hit || (state == FILL_DONE);
    assign touch_way_o  = (state == FILL_DONE) ? way_q : hit_way;

    assign resp_valid_o = hit || (state == FILL_DONE);
    assign rd_data_o    = (state == FILL_DONE) ? crit_q : hit_word;

    assign awvalid_o    = (state == WB_ADDR);
    assign awaddr_o     = {vtag_q, req_set, {OFF_W{1'b0}}};
    assign wvalid_o     = (state == WB_DATA);
    assign wdata_o      = arr.rd_data[way_q];
    assign wlast_o      = wvalid_o && (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1));
    assign bready_o     = (state == WB_RESP);
    assign arvalid_o    = (state == FILL_ADDR);
    assign araddr_o     = {addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign rready_o     = (state == FILL_DATA);

    always_comb begin
        arr.rd_en     = 1'b0;
        arr.rd_set    = req_set;
        arr.rd_word   = {beat_nxt, 1'b0};
        arr.wr_en     = '0;
        arr.wr_way    = way_q;
        arr.wr_word   = {req_set, beat_cnt, 1'b0};
        arr.wr_data   = rdata_i;
        arr.tag_en    = 1'b0;
        arr.tag_way   = way_q;
        arr.tag_set   = req_set;
        arr.tag       = req_tag;
        arr.tag_valid = 1'b1;
        arr.tag_dirty = wr_q;
        case (state)
            RUN: begin
                arr.rd_en   = accept;
                arr.rd_set  = addr_i[OFF_W +: SET_W];
                arr.rd_word = addr_i[BYTE_W +: WIDX_W];
                if (hit && wr_q) begin
                    arr.wr_en   = WPB'(1) << req_word[0];
                    arr.wr_way  = hit_way;
                    arr.wr_word = {req_set, req_word};
                    arr.wr_data = {WPB{merged}};
                    arr.tag_en  = 1'b1;     // mark line dirty
                    arr.tag_way = hit_way;
                end
            end
            WB_ADDR, WB_DATA: begin
                arr.rd_en = 1'b1;
            end
            FILL_DATA: begin
                arr.wr_en = {WPB{rvalid_i}};
            end
            FILL_DONE: begin
                arr.tag_en = 1'b1;
                if (wr_q) begin
                    arr.wr_en   = WPB'(1) << req_word[0];
                    arr.wr_word = {req_set, req_word};
                    arr.wr_data = {WPB{merged}};
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= RUN;
            req_q    <= 1'b0;
            beat_cnt <= '0;
        end else begin
            req_q <= accept;
            case (state)
                RUN: begin
                    beat_cnt <= '0;
                    if (miss) begin
                        state <= victim_dirty ? WB_ADDR : FILL_ADDR;
                    end
                end
                WB_ADDR: begin
                    if (awready_i) begin
                        state <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    if (wready_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast_o) begin
                            state <= WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    if (bvalid_i) begin
                        state <= FILL_ADDR;
                    end
                end
                FILL_ADDR: begin
                    if (arready_i) begin
                        state <= FILL_DATA;
                    end
                end
                FILL_DATA: begin
                    if (rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1)) begin
                            state <= FILL_DONE;
                        end
                    end
                end
                default: begin
                    state <= RUN;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= addr_i;
            wr_q    <= wr_i;
            wdata_q <= wr_data_i;
            mask_q  <= mask_i;
        end
        if (miss) begin
            way_q  <= victim_i;
            vtag_q <= arr.rd_tags[victim_i];
        end
        if (state == FILL_DATA && rvalid_i && beat_cnt == req_word[WIDX_W-1:1]) begin
            crit_q <= rdata_i[req_word[0]*WORD_W +: WORD_W];    // critical word
        end
    end

endmodule

/* rtl/dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 64;
    localparam int BUS_W          = 128;
    localparam int NUM_WAYS       = 4;
    localparam int WORDS_PER_LINE = 8;     // 64 byte lines
    localparam int BEATS_PER_LINE = 4;
    localparam int DEFAULT_SET_W  = 7;     // 128 sets

    typedef logic [ADDR_W-1:0]                  addr_t;
    typedef logic [WORD_W-1:0]                  word_t;
    typedef logic [BUS_W-1:0]                   beat_t;
    typedef logic [WORD_W/8-1:0]                mask_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]        way_t;
    typedef logic [NUM_WAYS-1:0]                way_vec_t;
    typedef logic [NUM_WAYS-2:0]                plru_t;
    typedef logic [$clog2(BEATS_PER_LINE)-1:0]  beat_cnt_t;

    typedef enum logic [2:0] {
        RUN,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        FILL_ADDR,
        FILL_DATA,
        FILL_DONE
    } ctrl_state_t;

endpackage

/* rtl/dcache_plru.sv */
`timescale 1ns/100ps

module dcache_plru
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        touch_en_i,
    input  way_t        touch_way_i,
    input  way_vec_t    valid_vec_i,
    output way_t        victim_o
);

    // bit 2 picks the pair, bit 1 ways 0/1, bit 0 ways 2/3
    plru_t tree_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tree_q <= '0;
        end else if (touch_en_i) begin
            case (touch_way_i)
                2'd0:    tree_q <= {1'b1, 1'b1, tree_q[0]};
                2'd1:    tree_q <= {1'b1, 1'b0, tree_q[0]};
                2'd2:    tree_q <= {1'b0, tree_q[1], 1'b1};
                default: tree_q <= {1'b0, tree_q[1], 1'b0};
            endcase
        end
    end

    always_comb begin
        victim_o = tree_q[2] ? {1'b1, tree_q[0]} : {1'b0, tree_q[1]};
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_vec_i[w]) begin
                victim_o = way_t'(w);   // lowest invalid way wins
            end
        end
    end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int SET_W = DEFAULT_SET_W
)(
    input  logic    clk,
    input  logic    resetn,

    input  logic    req_i,
    input  addr_t   addr_i,
    input  logic    wr_i,
    input  word_t   wr_data_i,
    input  mask_t   mask_i,
    output logic    ready_o,
    output logic    resp_valid_o,
    output word_t   rd_data_o,

    input  logic    arready_i,
    output addr_t   araddr_o,
    output logic    arvalid_o,
    input  logic    rvalid_i,
    input  beat_t   rdata_i,
    output logic    rready_o,
    input  logic    awready_i,
    output addr_t   awaddr_o,
    output logic    awvalid_o,
    input  logic    wready_i,
    output beat_t   wdata_o,
    output logic    wvalid_o,
    output logic    wlast_o,
    input  logic    bvalid_i,
    output logic    bready_o
);

    logic       touch_en;
    way_t       touch_way;
    way_vec_t   valid_vec;
    way_t       victim;

    dcache_array_if #(.SET_W(SET_W)) arr_if ();

    dcache_ctrl #(.SET_W(SET_W)) u_ctrl (
        .*,
        .arr         (arr_if.ctrl),
        .touch_en_o  (touch_en),
        .touch_way_o (touch_way),
        .valid_vec_o (valid_vec),
        .victim_i    (victim)
    );

    dcache_arrays #(.SET_W(SET_W)) u_arrays (
        .clk    (clk),
        .resetn (resetn),
        .arr    (arr_if.mem)
    );

    dcache_plru u_plru (
        .clk         (clk),
        .resetn      (resetn),
        .touch_en_i  (touch_en),
        .touch_way_i (touch_way),
        .valid_vec_i (valid_vec),
        .victim_o    (victim)
    );

endmodule

/* test/dcache_chk.sv */
`timescale 1ns/100ps

module dcache_chk
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     resetn,
    input logic     arvalid_i,
    input logic     arready_i,
    input logic     awvalid_i,
    input logic     awready_i,
    input logic     wvalid_i,
    input logic     wready_i,
    input logic     wlast_i,
    input logic     ready_i,
    input logic     resp_valid_i,
    input way_vec_t hit_vec_i
);

    beat_cnt_t wbeat_q;     // w beats taken so far in the line

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wbeat_q <= '0;
        end else if (wvalid_i && wready_i) begin
            wbeat_q <= wbeat_q + beat_cnt_t'(1);
        end
    end

    ar_held: assert property (@(posedge clk) disable iff (!resetn)
        arvalid_i && !arready_i |=> arvalid_i)
        else $error("arvalid dropped before arready");

    aw_held: assert property (@(posedge clk) disable iff (!resetn)
        awvalid_i && !awready_i |=> awvalid_i)
        else $error("awvalid dropped before awready");

    w_held: assert property (@(posedge clk) disable iff (!resetn)
        wvalid_i && !wready_i |=> wvalid_i)
        else $error("wvalid dropped before wready");

    wlast_beat: assert property (@(posedge clk) disable iff (!resetn)
        wvalid_i |-> (wlast_i == (wbeat_q == beat_cnt_t'(BEATS_PER_LINE - 1))))
        else $error("wlast not on the fourth beat");

    // fill response leaves ready low, it must be a single pulse
    fill_resp_pulse: assert property (@(posedge clk) disable iff (!resetn)
        resp_valid_i && !ready_i |=> !resp_valid_i)
        else $error("fill response longer than one cycle");

    one_hit: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(hit_vec_i))
        else $error("more than one way hits");

endmodule

/* test/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int SET_W      = DEFAULT_SET_W;
    localparam int LINE_BYTES = WORDS_PER_LINE * WORD_W / 8;
    localparam int OFF_W      = $clog2(LINE_BYTES);
    localparam int BEAT_BYTES = BUS_W / 8;
    localparam int TIMEOUT    = 500;
    localparam int N_RANDOM   = 400;

    typedef struct packed {
        logic   is_load;
        word_t  data;
        addr_t  addr;
    } exp_t;

    logic   clk;
    logic   resetn;
    logic   req;
    addr_t  addr;
    logic   wr;
    word_t  wr_data;
    mask_t  mask;
    logic   ready;
    logic   resp_valid;
    word_t  rd_data;
    logic   arready;
    addr_t  araddr;
    logic   arvalid;
    logic   rvalid;
    beat_t  rdata;
    logic   rready;
    logic   awready;
    addr_t  awaddr;
    logic   awvalid;
    logic   wready;
    beat_t  wdata;
    logic   wvalid;
    logic   wlast;
    logic   bvalid;
    logic   bready;

    beat_t       mem_beats [addr_t];   // backing memory, by beat address
    word_t       shadow [addr_t];      // cpu view, by word address
    exp_t        exp_q [$];
    int unsigned wb_count;
    addr_t       last_awaddr;

    tb_clock u_clock (.clk_o(clk));

    dcache_top #(.SET_W(SET_W)) UUT (
        .clk          (clk),
        .resetn       (resetn),
        .req_i        (req),
        .addr_i       (addr),
        .wr_i         (wr),
        .wr_data_i    (wr_data),
        .mask_i       (mask),
        .ready_o      (ready),
        .resp_valid_o (resp_valid),
        .rd_data_o    (rd_data),
        .arready_i    (arready),
        .araddr_o     (araddr),
        .arvalid_o    (arvalid),
        .rvalid_i     (rvalid),
        .rdata_i      (rdata),
        .rready_o     (rready),
        .awready_i    (awready),
        .awaddr_o     (awaddr),
        .awvalid_o    (awvalid),
        .wready_i     (wready),
        .wdata_o      (wdata),
        .wvalid_o     (wvalid),
        .wlast_o      (wlast),
        .bvalid_i     (bvalid),
        .bready_o     (bready)
    );

    bind dcache_top dcache_chk u_chk (
        .clk          (clk),
        .resetn       (resetn),
        .arvalid_i    (arvalid_o),
        .arready_i    (arready_i),
        .awvalid_i    (awvalid_o),
        .awready_i    (awready_i),
        .wvalid_i     (wvalid_o),
        .wready_i     (wready_i),
        .wlast_i      (wlast_o),
        .ready_i      (ready_o),
        .resp_valid_i (resp_valid_o),
        .hit_vec_i    (u_ctrl.hit_vec)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic word_t init_word(addr_t a);
        return {a ^ 32'h9e37_79b9, ~a};     // whole address goes in
    endfunction

    function automatic beat_t mem_read(addr_t a);
        if (mem_beats.exists(a)) begin
            return mem_beats[a];
        end
        return {init_word(a + 32'd8), init_word(a)};
    endfunction

    function automatic word_t shadow_read(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    // reference model of a byte-masked store
    function automatic word_t apply_store(word_t old_w, word_t new_w, mask_t m);
        word_t bits;
        for (int b = 0; b < WORD_W / 8; b++) begin
            bits[b*8 +: 8] = {8{m[b]}};
        end
        return (old_w & ~bits) | (new_w & bits);
    endfunction

    function automatic addr_t make_addr(int unsigned tag, int unsigned set, int unsigned word);
        return (addr_t'(tag) << (SET_W + OFF_W)) | (addr_t'(set) << OFF_W)
            | (addr_t'(word) << 3);
    endfunction

    task automatic idle_random();
        int n;
        n = int'($urandom_range(3, 0));
        repeat (n) @(negedge clk);
    endtask

    task automatic issue(input logic is_wr, input addr_t a, input word_t d, input mask_t m);
        int   waited;
        exp_t e;
        waited = 0;
        req = 1'b1;
        wr = is_wr;
        addr = a;
        wr_data = d;
        mask = m;
        while (!ready) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT) else abort_run("timeout: request never accepted");
        end
        e.is_load = !is_wr;
        e.addr = {a[ADDR_W-1:3], 3'b000};
        if (is_wr) begin
            shadow[e.addr] = apply_store(shadow_read(e.addr), d, m);
        end
        e.data = shadow_read(e.addr);
        exp_q.push_back(e);
        @(negedge clk);     // taken at the posedge in between
        req = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT) else abort_run("timeout waiting for responses");
        end
    endtask

    task automatic serve_write();
        int    waited;
        addr_t base;
        addr_t wa;
        beat_t exp_beat;
        idle_random();
        base = awaddr;
        awready = 1'b1;
        @(negedge clk);
        awready = 1'b0;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            waited = 0;
            while (!wvalid) begin
                @(negedge clk);
                waited++;
                assert (waited < TIMEOUT) else abort_run("timeout waiting for wvalid_o");
            end
            idle_random();
            wa = base + addr_t'(BEAT_BYTES * b);
            exp_beat = {shadow_read(wa + 32'd8), shadow_read(wa)};
            assert (wdata == exp_beat) else abort_run($sformatf(
                "FAILED at %0t: wdata_o = %h, expected %h", $time, wdata, exp_beat));
            assert (wlast == (b == BEATS_PER_LINE - 1)) else abort_run($sformatf(
                "FAILED at %0t: wlast_o = %b, expected %b", $time, wlast,
                b == BEATS_PER_LINE - 1));
            mem_beats[wa] = wdata;
            wready = 1'b1;
            @(negedge clk);
            wready = 1'b0;
        end
        waited = 0;
        while (!bready) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT) else abort_run("timeout waiting for bready_o");
        end
        idle_random();
        bvalid = 1'b1;
        @(negedge clk);
        bvalid = 1'b0;
        last_awaddr = base;
        wb_count++;
    endtask

    task automatic serve_read();
        int    waited;
        addr_t base;
        addr_t exp_line;
        exp_t  pend;
        idle_random();
        base = araddr;
        assert (exp_q.size() != 0)
            else abort_run("fill requested with no request outstanding");
        pend = exp_q[0];    // the missing request is the only one in flight
        exp_line = {pend.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        assert (base == exp_line) else abort_run($sformatf(
            "FAILED at %0t: araddr_o = %h, expected %h", $time, base, exp_line));
        arready = 1'b1;
        @(negedge clk);
        arready = 1'b0;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            idle_random();
            waited = 0;
            while (!rready) begin
                @(negedge clk);
                waited++;
                assert (waited < TIMEOUT) else abort_run("timeout waiting for rready_o");
            end
            rvalid = 1'b1;
            rdata = mem_read(base + addr_t'(BEAT_BYTES * b));
            @(negedge clk);
            rvalid = 1'b0;
        end
    endtask

    initial begin : memory_model
        forever begin
            @(negedge clk);
            if (resetn && awvalid) begin
                serve_write();          // writeback always comes before its fill
            end else if (resetn && arvalid) begin
                serve_read();
            end
        end
    end

    // responses come back in request order
    always @(negedge clk) begin : compare
        exp_t e;
        if (resetn && resp_valid) begin
            assert (exp_q.size() > 0)
                else abort_run("resp_valid_o pulsed with no request outstanding");
            e = exp_q.pop_front();
            if (e.is_load) begin
                assert (rd_data == e.data) else abort_run($sformatf(
                    "FAILED at %0t: rd_data_o = %h, expected %h (address %h)",
                    $time, rd_data, e.data, e.addr));
            end
        end
    end

    initial begin : stimulus
        addr_t       a;
        addr_t       lines [4];
        int unsigned wb_before;
        logic        found;
        logic        is_wr;
        void'($urandom(32'ha202));
        req = 1'b0;
        addr = '0;
        wr = 1'b0;
        wr_data = '0;
        mask = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        wb_count = 0;
        last_awaddr = '0;
        resetn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        assert (!arvalid && !awvalid && !wvalid && !rready && !bready && !resp_valid && ready)
            else abort_run("outputs are not at their reset values");
        resetn = 1'b1;

        // cold load gives the memory pattern
        issue(1'b0, make_addr(3, 1, 5), '0, '0);
        wait_idle();

        // store then load, back to back and later
        a = make_addr(7, 2, 3);
        issue(1'b0, a, '0, '0);
        wait_idle();
        issue(1'b1, a, {$urandom, $urandom}, mask_t'($urandom_range(255, 1)));
        issue(1'b0, a, '0, '0);
        issue(1'b0, make_addr(7, 2, 6), '0, '0);
        issue(1'b0, a, '0, '0);
        issue(1'b1, make_addr(9, 2, 1), {$urandom, $urandom}, mask_t'($urandom_range(255, 1)));
        issue(1'b0, make_addr(9, 2, 1), '0, '0);
        wait_idle();

        // cached line answers one cycle later
        issue(1'b0, a, '0, '0);
        assert (resp_valid) else abort_run($sformatf(
            "FAILED at %0t: resp_valid_o = %b, expected 1", $time, resp_valid));
        assert (ready) else abort_run($sformatf(
            "FAILED at %0t: ready_o = %b, expected 1", $time, ready));
        wait_idle();

        // five tags into one set force a writeback
        for (int t = 0; t < 4; t++) begin
            lines[t] = make_addr(t + 1, 5, 0);
            issue(1'b1, make_addr(t + 1, 5, $urandom_range(7, 0)), {$urandom, $urandom},
                mask_t'($urandom_range(255, 1)));
        end
        wait_idle();
        wb_before = wb_count;
        issue(1'b1, make_addr(5, 5, 2), {$urandom, $urandom}, mask_t'($urandom_range(255, 1)));
        wait_idle();
        assert (wb_count == wb_before + 1) else abort_run($sformatf(
            "FAILED at %0t: writeback count = %0d, expected %0d", $time, wb_count,
            wb_before + 1));
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (last_awaddr == lines[i]) begin
                found = 1'b1;
            end
        end
        assert (found) else abort_run($sformatf(
            "writeback went to %h, which is not a line stored before", last_awaddr));

        // random mix over a few sets
        for (int n = 0; n < N_RANDOM; n++) begin
            is_wr = $urandom_range(1, 0) == 1;
            a = make_addr($urandom_range(5, 0) + 16, $urandom_range(2, 0) + 8,
                $urandom_range(7, 0));
            issue(is_wr, a, {$urandom, $urandom}, mask_t'($urandom_range(255, 0)));
        end
        wait_idle();

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_NS = 20     // 40 ns period
)(
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_NS clk_o = ~clk_o;
        end
    end

endmodule
